/* event_log_top.f */
rtl/log_mem_pkg.sv
rtl/log_cmd_pkg.sv
rtl/sdpram_generic.sv
rtl/log_writer.sv
rtl/write_arbiter.sv
rtl/event_log_top.sv
verification/event_log_asserts.sv
verification/event_log_tb.sv

/* verification/event_log_tb.sv */
`timescale 1ns/100ps

module event_log_tb;

    logic                                 clk = 1'b0;
    logic                                 rst;
    logic                                 cmd_valid_0;
    logic                                 cmd_valid_1;
    log_cmd_pkg::log_op_t                 cmd_op_0;
    log_cmd_pkg::log_op_t                 cmd_op_1;
    logic [log_mem_pkg::DATA_WIDTH-1:0]   cmd_data_0;
    logic [log_mem_pkg::DATA_WIDTH-1:0]   cmd_data_1;
    logic                                 rd_en;
    logic [log_mem_pkg::ADDR_WIDTH-1:0]   rd_addr;
    logic                                 busy_0;
    logic                                 busy_1;
    logic                                 drop_0;
    logic                                 drop_1;
    logic [log_mem_pkg::PTR_WIDTH-1:0]    level_0;
    logic [log_mem_pkg::PTR_WIDTH-1:0]    level_1;
    logic                                 wrapped_0;
    logic                                 wrapped_1;
    logic [log_mem_pkg::DATA_WIDTH-1:0]   rd_data;

    int errors;
    int timeouts;
    int assert_fails;
    // reference model of the RAM, the pointers and the arbiter history
    logic [log_mem_pkg::DATA_WIDTH-1:0]   model_mem [log_mem_pkg::MEM_WORDS];
    logic [log_mem_pkg::PTR_WIDTH-1:0]    model_ptr [log_mem_pkg::NUM_CHANNELS];
    logic                                 model_wrapped [log_mem_pkg::NUM_CHANNELS];
    int                                   model_last;

    event_log_top u_dut (
        .clk         (clk),
        .rst         (rst),
        .cmd_valid_0 (cmd_valid_0),
        .cmd_op_0    (cmd_op_0),
        .cmd_data_0  (cmd_data_0),
        .cmd_valid_1 (cmd_valid_1),
        .cmd_op_1    (cmd_op_1),
        .cmd_data_1  (cmd_data_1),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .busy_0      (busy_0),
        .busy_1      (busy_1),
        .drop_0      (drop_0),
        .drop_1      (drop_1),
        .level_0     (level_0),
        .level_1     (level_1),
        .wrapped_0   (wrapped_0),
        .wrapped_1   (wrapped_1),
        .rd_data     (rd_data)
    );

    always #20 clk = ~clk;

    task automatic check_word(input string name, input logic [log_mem_pkg::DATA_WIDTH-1:0] exp,
                              input logic [log_mem_pkg::DATA_WIDTH-1:0] act);
        if (act !== exp) begin
            errors++;
            $display("ERR %s: expected 0x%04h, actual 0x%04h", name, exp, act);
        end
    endtask

    task automatic check_level(input string name, input logic [log_mem_pkg::PTR_WIDTH-1:0] exp,
                               input logic [log_mem_pkg::PTR_WIDTH-1:0] act);
        if (act !== exp) begin
            errors++;
            $display("ERR %s: expected level %0d, actual level %0d", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("ERR %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    function automatic logic [log_mem_pkg::DATA_WIDTH-1:0] rand_word();
        int unsigned r;
        r = $urandom();
        return r[log_mem_pkg::DATA_WIDTH-1:0];
    endfunction

    function automatic logic [log_mem_pkg::ADDR_WIDTH-1:0] word_addr(input int ch, input int slot);
        int a;
        a = ch * log_mem_pkg::REGION_WORDS + slot;
        return a[log_mem_pkg::ADDR_WIDTH-1:0];
    endfunction

    function automatic logic channel_busy(input int ch);
        return (ch == 0) ? busy_0 : busy_1;
    endfunction

    function automatic logic channel_drop(input int ch);
        return (ch == 0) ? drop_0 : drop_1;
    endfunction

    function automatic logic channel_wrapped(input int ch);
        return (ch == 0) ? wrapped_0 : wrapped_1;
    endfunction

    function automatic logic [log_mem_pkg::PTR_WIDTH-1:0] channel_level(input int ch);
        return (ch == 0) ? level_0 : level_1;
    endfunction

    function automatic void model_append(input int ch, input logic [log_mem_pkg::DATA_WIDTH-1:0] d);
        model_mem[word_addr(ch, int'(model_ptr[ch]))] = d;
        if (int'(model_ptr[ch]) == log_mem_pkg::REGION_WORDS - 1) begin
            model_wrapped[ch] = 1'b1;
        end
        model_ptr[ch] = model_ptr[ch] + 1'b1;
    endfunction

    task automatic drive_cmd(input int ch, input log_cmd_pkg::log_op_t op,
                             input logic [log_mem_pkg::DATA_WIDTH-1:0] d);
        if (ch == 0) begin
            cmd_valid_0 <= 1'b1;
            cmd_op_0    <= op;
            cmd_data_0  <= d;
        end else begin
            cmd_valid_1 <= 1'b1;
            cmd_op_1    <= op;
            cmd_data_1  <= d;
        end
    endtask

    task automatic release_cmds();
        cmd_valid_0 <= 1'b0;
        cmd_valid_1 <= 1'b0;
    endtask

    task automatic wait_idle(input int ch, input string name);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (channel_busy(ch) && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        if (channel_busy(ch)) begin
            timeouts++;
            $display("%s: channel %0d stayed busy for 20 cycles without a write", name, ch);
        end
    endtask

    task automatic append(input int ch, input logic [log_mem_pkg::DATA_WIDTH-1:0] d,
                          input string name);
        @(posedge clk);
        drive_cmd(ch, log_cmd_pkg::OP_APPEND, d);
        @(posedge clk);
        release_cmds();
        model_append(ch, d);
        wait_idle(ch, name);
        model_last = ch;
    endtask

    task automatic clear_channel(input int ch);
        @(posedge clk);
        drive_cmd(ch, log_cmd_pkg::OP_CLEAR, '0);
        @(posedge clk);
        release_cmds();
        model_ptr[ch] = '0;
        model_wrapped[ch] = 1'b0;
        @(negedge clk);
    endtask

    // address sampled at one edge, data valid after READ_LATENCY more edges
    task automatic read_word(input logic [log_mem_pkg::ADDR_WIDTH-1:0] addr,
                             output logic [log_mem_pkg::DATA_WIDTH-1:0] d);
        @(posedge clk);
        rd_en   <= 1'b1;
        rd_addr <= addr;
        @(posedge clk);
        rd_en <= 1'b0;
        repeat (log_mem_pkg::READ_LATENCY) @(posedge clk);
        @(negedge clk);
        d = rd_data;
    endtask

    task automatic check_region(input int ch, input int count, input string name);
        logic [log_mem_pkg::DATA_WIDTH-1:0] got;
        for (int slot = 0; slot < count; slot++) begin
            read_word(word_addr(ch, slot), got);
            check_word(name, model_mem[word_addr(ch, slot)], got);
        end
    endtask

    task automatic test_single_append();
        logic [log_mem_pkg::DATA_WIDTH-1:0] d;
        logic [log_mem_pkg::DATA_WIDTH-1:0] got;
        logic [log_mem_pkg::PTR_WIDTH-1:0]  old_level;
        for (int ch = 0; ch < log_mem_pkg::NUM_CHANNELS; ch++) begin
            old_level = model_ptr[ch];
            d = rand_word();
            append(ch, d, "test_single_append");
            check_level("test_single_append", old_level + 1'b1, channel_level(ch));
            read_word(word_addr(ch, int'(old_level)), got);
            check_word("test_single_append", d, got);
        end
    endtask

    task automatic test_contention();
        logic [log_mem_pkg::DATA_WIDTH-1:0] d0;
        logic [log_mem_pkg::DATA_WIDTH-1:0] d1;
        logic [log_mem_pkg::PTR_WIDTH-1:0]  lvl0;
        logic [log_mem_pkg::PTR_WIDTH-1:0]  lvl1;
        int winner;
        for (int iter = 0; iter < 4; iter++) begin
            // a lone channel 0 write hands the next tie to channel 1
            if (iter % 2 == 1) begin
                append(0, rand_word(), "test_contention");
            end
            d0 = rand_word();
            d1 = rand_word();
            lvl0 = model_ptr[0];
            lvl1 = model_ptr[1];
            winner = (model_last == 0) ? 1 : 0;
            @(posedge clk);
            drive_cmd(0, log_cmd_pkg::OP_APPEND, d0);
            drive_cmd(1, log_cmd_pkg::OP_APPEND, d1);
            @(posedge clk);
            release_cmds();
            model_append(0, d0);
            model_append(1, d1);
            // winner commits on the next edge, the loser one edge later
            @(posedge clk);
            @(negedge clk);
            check_flag("test_contention", 1'b0, channel_busy(winner));
            check_flag("test_contention", 1'b1, channel_busy(1 - winner));
            wait_idle(0, "test_contention");
            wait_idle(1, "test_contention");
            model_last = 1 - winner;
            check_level("test_contention", lvl0 + 1'b1, level_0);
            check_level("test_contention", lvl1 + 1'b1, level_1);
        end
        check_region(0, int'(model_ptr[0]), "test_contention");
        check_region(1, int'(model_ptr[1]), "test_contention");
    endtask

    task automatic test_drop();
        logic [log_mem_pkg::DATA_WIDTH-1:0] first;
        logic [log_mem_pkg::DATA_WIDTH-1:0] got;
        logic [log_mem_pkg::PTR_WIDTH-1:0]  lvl;
        for (int ch = 0; ch < log_mem_pkg::NUM_CHANNELS; ch++) begin
            first = rand_word();
            lvl = model_ptr[ch];
            @(posedge clk);
            drive_cmd(ch, log_cmd_pkg::OP_APPEND, first);
            @(posedge clk);
            drive_cmd(ch, log_cmd_pkg::OP_APPEND, rand_word());
            model_append(ch, first);
            @(negedge clk);
            check_flag("test_drop", 1'b0, channel_drop(ch));
            @(posedge clk);
            release_cmds();
            @(negedge clk);
            check_flag("test_drop", 1'b1, channel_drop(ch));
            wait_idle(ch, "test_drop");
            model_last = ch;
            check_flag("test_drop", 1'b0, channel_drop(ch));
            check_level("test_drop", lvl + 1'b1, channel_level(ch));
            read_word(word_addr(ch, int'(lvl)), got);
            check_word("test_drop", first, got);
        end
    endtask

    task automatic test_clear();
        logic [log_mem_pkg::DATA_WIDTH-1:0] d;
        logic [log_mem_pkg::DATA_WIDTH-1:0] got;
        int count;
        for (int ch = 0; ch < log_mem_pkg::NUM_CHANNELS; ch++) begin
            // a wrapped region has every slot written
            count = model_wrapped[ch] ? log_mem_pkg::REGION_WORDS : int'(model_ptr[ch]);
            clear_channel(ch);
            check_level("test_clear", '0, channel_level(ch));
            check_flag("test_clear", 1'b0, channel_wrapped(ch));
            check_region(ch, count, "test_clear");
            d = rand_word();
            append(ch, d, "test_clear");
            check_level("test_clear", 4'd1, channel_level(ch));
            read_word(word_addr(ch, 0), got);
            check_word("test_clear", d, got);
        end
    endtask

    task automatic test_wrap();
        logic [log_mem_pkg::DATA_WIDTH-1:0] entries [17];
        logic [log_mem_pkg::DATA_WIDTH-1:0] got;
        clear_channel(1);
        for (int i = 0; i < 17; i++) begin
            entries[i] = rand_word();
            append(1, entries[i], "test_wrap");
            if (i == 14) begin
                check_flag("test_wrap", 1'b0, wrapped_1);
            end
        end
        check_flag("test_wrap", 1'b1, wrapped_1);
        check_level("test_wrap", 4'd1, level_1);
        read_word(word_addr(1, 0), got);
        check_word("test_wrap", entries[16], got);
        read_word(word_addr(1, 1), got);
        check_word("test_wrap", entries[1], got);
    endtask

    task automatic test_read_hold();
        logic [log_mem_pkg::DATA_WIDTH-1:0] held;
        read_word(word_addr(1, 0), held);
        check_word("test_read_hold", model_mem[word_addr(1, 0)], held);
        for (int i = 1; i < 5; i++) begin
            @(posedge clk);
            rd_addr <= word_addr(0, i);
            @(negedge clk);
            check_word("test_read_hold", held, rd_data);
        end
    endtask

    initial begin
        void'($urandom(44888));
        errors = 0;
        timeouts = 0;
        model_last = 1;
        for (int ch = 0; ch < log_mem_pkg::NUM_CHANNELS; ch++) begin
            model_ptr[ch] = '0;
            model_wrapped[ch] = 1'b0;
        end
        rst = 1'b1;
        cmd_valid_0 = 1'b0;
        cmd_valid_1 = 1'b0;
        cmd_op_0 = log_cmd_pkg::OP_APPEND;
        cmd_op_1 = log_cmd_pkg::OP_APPEND;
        cmd_data_0 = '0;
        cmd_data_1 = '0;
        rd_en = 1'b0;
        rd_addr = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        test_single_append();
        test_contention();
        test_drop();
        test_wrap();
        test_clear();
        test_read_hold();

        repeat (4) @(posedge clk);
        assert_fails = u_dut.u_arbiter.u_arb_asserts.fails
                     + u_dut.u_writer_0.u_writer_asserts.fails
                     + u_dut.u_writer_1.u_writer_asserts.fails;
        $display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
                 errors, timeouts, assert_fails);
        if (errors == 0 && timeouts == 0 && assert_fails == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule : event_log_tb

/* verification/event_log_asserts.sv */
`timescale 1ns/100ps

module event_log_asserts (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [log_mem_pkg::NUM_CHANNELS-1:0] req,
    input  logic [log_mem_pkg::NUM_CHANNELS-1:0] grant,
    input  logic                                 cmd_valid,
    input  logic                                 busy,
    input  logic                                 drop
);

    int fails = 0;

    grant_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
        else begin
            $error("grant is not one-hot or zero: %b", grant);
            fails = fails + 1;
        end

    grant_to_requester: assert property (@(posedge clk) disable iff (rst) (grant & ~req) == '0)
        else begin
            $error("grant %b given to a channel without req %b", grant, req);
            fails = fails + 1;
        end

    for (genvar i = 0; i < log_mem_pkg::NUM_CHANNELS; i++) begin : g_req_drop
        req_after_grant: assert property (@(posedge clk) disable iff (rst)
            req[i] && grant[i] |=> !req[i])
            else begin
                $error("req %0d still high after its grant", i);
                fails = fails + 1;
            end
    end

    // a command that meets a pending entry is reported one cycle later
    drop_on_reject: assert property (@(posedge clk) disable iff (rst)
        cmd_valid && busy |=> drop)
        else begin
            $error("command arrived while busy but no drop followed");
            fails = fails + 1;
        end

    drop_not_accepted: assert property (@(posedge clk) disable iff (rst)
        drop |-> $past(cmd_valid && busy))
        else begin
            $error("drop pulsed for a command that was accepted");
            fails = fails + 1;
        end

endmodule : event_log_asserts

bind write_arbiter event_log_asserts u_arb_asserts (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .grant     (grant),
    .cmd_valid (1'b0),
    .busy      (1'b0),
    .drop      (1'b0)
);

bind log_writer event_log_asserts u_writer_asserts (
    .clk       (clk),
    .rst       (rst),
    .req       ({1'b0, req}),
    .grant     ({1'b0, grant}),
    .cmd_valid (cmd_valid),
    .busy      (busy),
    .drop      (drop)
);

/* rtl/event_log_top.sv */
`timescale 1ns/100ps

module event_log_top (
    input  logic                                 clk,
    input  logic                                 rst,

    input  logic                                 cmd_valid_0,
    input  log_cmd_pkg::log_op_t                 cmd_op_0,
    input  logic [log_mem_pkg::DATA_WIDTH-1:0]   cmd_data_0,

    input  logic                                 cmd_valid_1,
    input  log_cmd_pkg::log_op_t                 cmd_op_1,
    input  logic [log_mem_pkg::DATA_WIDTH-1:0]   cmd_data_1,

    input  logic                                 rd_en,
    input  logic [log_mem_pkg::ADDR_WIDTH-1:0]   rd_addr,

    output logic                                 busy_0,
    output logic                                 busy_1,
    output logic                                 drop_0,
    output logic                                 drop_1,
    output logic [log_mem_pkg::PTR_WIDTH-1:0]    level_0,
    output logic [log_mem_pkg::PTR_WIDTH-1:0]    level_1,
    output logic                                 wrapped_0,
    output logic                                 wrapped_1,
    output logic [log_mem_pkg::DATA_WIDTH-1:0]   rd_data
);

    logic [log_mem_pkg::NUM_CHANNELS-1:0]  req;
    logic [log_mem_pkg::NUM_CHANNELS-1:0]  grant;
    logic [log_mem_pkg::ADDR_WIDTH-1:0]    wr_addr_0;
    logic [log_mem_pkg::ADDR_WIDTH-1:0]    wr_addr_1;
    logic [log_mem_pkg::DATA_WIDTH-1:0]    wr_data_0;
    logic [log_mem_pkg::DATA_WIDTH-1:0]    wr_data_1;

    // RAM write port, owned by the arbiter
    logic                                  we_a;
    logic [log_mem_pkg::ADDR_WIDTH-1:0]    addr_a;
    logic [log_mem_pkg::DATA_WIDTH-1:0]    w_data_a;

    log_writer #(
        .CHANNEL (0)
    ) u_writer_0 (
        .clk       (clk),
        .rst       (rst),
        .cmd_valid (cmd_valid_0),
        .cmd_op    (cmd_op_0),
        .cmd_data  (cmd_data_0),
        .grant     (grant[0]),
        .req       (req[0]),
        .wr_addr   (wr_addr_0),
        .wr_data   (wr_data_0),
        .busy      (busy_0),
        .drop      (drop_0),
        .level     (level_0),
        .wrapped   (wrapped_0)
    );

    log_writer #(
        .CHANNEL (1)
    ) u_writer_1 (
        .clk       (clk),
        .rst       (rst),
        .cmd_valid (cmd_valid_1),
        .cmd_op    (cmd_op_1),
        .cmd_data  (cmd_data_1),
        .grant     (grant[1]),
        .req       (req[1]),
        .wr_addr   (wr_addr_1),
        .wr_data   (wr_data_1),
        .busy      (busy_1),
        .drop      (drop_1),
        .level     (level_1),
        .wrapped   (wrapped_1)
    );

    write_arbiter u_arbiter (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .wr_addr_0 (wr_addr_0),
        .wr_addr_1 (wr_addr_1),
        .wr_data_0 (wr_data_0),
        .wr_data_1 (wr_data_1),
        .grant     (grant),
        .we        (we_a),
        .mem_addr  (addr_a),
        .mem_data  (w_data_a)
    );

    // host read port goes straight to the RAM
    sdpram_generic #(
        .READ_LATENCY (log_mem_pkg::READ_LATENCY),
        .ADDR_WIDTH   (log_mem_pkg::ADDR_WIDTH),
        .DATA_WIDTH   (log_mem_pkg::DATA_WIDTH),
        .MEM_WORDS    (log_mem_pkg::MEM_WORDS)
    ) u_ram (
        .clk      (clk),
        .rst      (rst),
        .we_a     (we_a),
        .addr_a   (addr_a),
        .w_data_a (w_data_a),
        .re_b     (rd_en),
        .addr_b   (rd_addr),
        .r_data_b (rd_data)
    );

endmodule : event_log_top

/* rtl/write_arbiter.sv */
`timescale 1ns/100ps

module write_arbiter (
    input  logic                                   clk,
    input  logic                                   rst,

    input  logic [log_mem_pkg::NUM_CHANNELS-1:0]   req,
    input  logic [log_mem_pkg::ADDR_WIDTH-1:0]     wr_addr_0,
    input  logic [log_mem_pkg::ADDR_WIDTH-1:0]     wr_addr_1,
    input  logic [log_mem_pkg::DATA_WIDTH-1:0]     wr_data_0,
    input  logic [log_mem_pkg::DATA_WIDTH-1:0]     wr_data_1,

    output logic [log_mem_pkg::NUM_CHANNELS-1:0]   grant,
    output logic                                   we,
    output logic [log_mem_pkg::ADDR_WIDTH-1:0]     mem_addr,
    output logic [log_mem_pkg::DATA_WIDTH-1:0]     mem_data
);

    // two named write ports, so the channel count is fixed here
    if (log_mem_pkg::NUM_CHANNELS != 2) begin : g_bad_channels
        $error("write_arbiter: supports exactly two channels, got %0d",
               log_mem_pkg::NUM_CHANNELS);
    end

    // high when channel 1 took the last grant
    logic last_grant;
    logic contest;

    assign contest = req[0] & req[1];

    // a lone requester always wins, a tie goes to the channel not served last
    always_comb begin
        grant[0] = req[0] & (~contest | last_grant);
        grant[1] = req[1] & (~contest | ~last_grant);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            // channel 0 wins the first contest after reset
            last_grant <= 1'b1;
        end else if (grant[0]) begin
            last_grant <= 1'b0;
        end else if (grant[1]) begin
            last_grant <= 1'b1;
        end
    end

    assign we = |grant;

    always_comb begin
        if (grant[1]) begin
            mem_addr = wr_addr_1;
            mem_data = wr_data_1;
        end else begin
            mem_addr = wr_addr_0;
            mem_data = wr_data_0;
        end
    end

endmodule : write_arbiter

/* rtl/log_writer.sv */
`timescale 1ns/100ps

module log_writer #(
    parameter int CHANNEL = 0
) (
    input  logic                                 clk,
    input  logic                                 rst,

    input  logic                                 cmd_valid,
    input  log_cmd_pkg::log_op_t                 cmd_op,
    input  logic [log_mem_pkg::DATA_WIDTH-1:0]   cmd_data,

    input  logic                                 grant,
    output logic                                 req,
    output logic [log_mem_pkg::ADDR_WIDTH-1:0]   wr_addr,
    output logic [log_mem_pkg::DATA_WIDTH-1:0]   wr_data,

    output logic                                 busy,
    output logic                                 drop,
    output logic [log_mem_pkg::PTR_WIDTH-1:0]    level,
    output logic                                 wrapped
);

    localparam int unsigned BASE_INT = CHANNEL * log_mem_pkg::REGION_WORDS;
    localparam logic [log_mem_pkg::ADDR_WIDTH-1:0] REGION_BASE =
        BASE_INT[log_mem_pkg::ADDR_WIDTH-1:0];
    localparam int PAD_WIDTH = log_mem_pkg::ADDR_WIDTH - log_mem_pkg::PTR_WIDTH;

    if (CHANNEL < 0 || CHANNEL >= log_mem_pkg::NUM_CHANNELS) begin : g_bad_channel
        $error("log_writer: CHANNEL %0d out of range", CHANNEL);
    end

    // pointer rollover relies on a power-of-two region
    if (log_mem_pkg::REGION_WORDS != (1 << log_mem_pkg::PTR_WIDTH)) begin : g_bad_region
        $error("log_writer: REGION_WORDS must be a power of two");
    end

    log_cmd_pkg::writer_state_t            state;
    logic [log_mem_pkg::PTR_WIDTH-1:0]     ptr;
    logic [log_mem_pkg::PTR_WIDTH:0]       ptr_inc;
    logic [log_mem_pkg::DATA_WIDTH-1:0]    entry;
    logic                                  accept_append;

    assign accept_append = (state == log_cmd_pkg::ST_IDLE) && cmd_valid &&
                           (cmd_op == log_cmd_pkg::OP_APPEND);

    // carry out of the increment is the rollover from the last slot to 0
    assign ptr_inc = {1'b0, ptr} + 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= log_cmd_pkg::ST_IDLE;
            ptr     <= '0;
            wrapped <= 1'b0;
            drop    <= 1'b0;
        end else begin
            drop <= 1'b0;
            case (state)
                log_cmd_pkg::ST_IDLE: begin
                    if (cmd_valid) begin
                        if (cmd_op == log_cmd_pkg::OP_CLEAR) begin
                            ptr     <= '0;
                            wrapped <= 1'b0;
                        end else begin
                            state <= log_cmd_pkg::ST_PENDING;
                        end
                    end
                end
                log_cmd_pkg::ST_PENDING: begin
                    // any command here is lost, including a clear
                    if (cmd_valid) begin
                        drop <= 1'b1;
                    end
                    if (grant) begin
                        state <= log_cmd_pkg::ST_IDLE;
                        ptr   <= ptr_inc[log_mem_pkg::PTR_WIDTH-1:0];
                        if (ptr_inc[log_mem_pkg::PTR_WIDTH]) begin
                            wrapped <= 1'b1;
                        end
                    end
                end
                default: begin
                    state <= log_cmd_pkg::ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept_append) begin
            entry <= cmd_data;
        end
    end

    assign req     = (state == log_cmd_pkg::ST_PENDING);
    assign busy    = req;
    assign wr_addr = REGION_BASE + {{PAD_WIDTH{1'b0}}, ptr};
    assign wr_data = entry;
    assign level   = ptr;

endmodule : log_writer

/* rtl/sdpram_generic.sv */
`timescale 1ns/100ps

module sdpram_generic #(
    parameter int READ_LATENCY = 1,
    parameter int ADDR_WIDTH   = 8,
    parameter int DATA_WIDTH   = 16,
    parameter int MEM_WORDS    = 256
) (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  we_a,
    input  logic [ADDR_WIDTH-1:0] addr_a,
    input  logic [DATA_WIDTH-1:0] w_data_a,

    input  logic                  re_b,
    input  logic [ADDR_WIDTH-1:0] addr_b,
    output logic [DATA_WIDTH-1:0] r_data_b
);

    if (MEM_WORDS > (1 << ADDR_WIDTH)) begin : g_bad_size
        $error("sdpram_generic: MEM_WORDS (%0d) exceeds range of ADDR_WIDTH (%0d)",
               MEM_WORDS, ADDR_WIDTH);
    end

    if (READ_LATENCY < 0) begin : g_bad_latency
        $error("sdpram_generic: negative READ_LATENCY (%0d)", READ_LATENCY);
    end

    logic [DATA_WIDTH-1:0] mem [MEM_WORDS];

    always_ff @(posedge clk) begin
        if (!rst && we_a) begin
            mem[addr_a] <= w_data_a;
        end
    end

    if (READ_LATENCY == 0) begin : g_comb_read
        assign r_data_b = mem[addr_b];
    end else begin : g_reg_read
        // load_q[i] marks that stage i took fresh data on the last edge
        logic [READ_LATENCY-1:0] load_q;
        logic [DATA_WIDTH-1:0]   pipe [READ_LATENCY];

        always_ff @(posedge clk) begin
            if (rst) begin
                load_q <= '0;
            end else begin
                load_q[0] <= re_b;
                for (int i = 1; i < READ_LATENCY; i++) begin
                    load_q[i] <= load_q[i-1];
                end
            end
        end

        // old data wins on a same-address write, the array read sees the pre-edge value
        always_ff @(posedge clk) begin
            if (re_b) begin
                pipe[0] <= mem[addr_b];
            end
            for (int i = 1; i < READ_LATENCY; i++) begin
                if (load_q[i-1]) begin
                    pipe[i] <= pipe[i-1];
                end
            end
        end

        assign r_data_b = pipe[READ_LATENCY-1];
    end

endmodule : sdpram_generic

/* rtl/log_cmd_pkg.sv */
package log_cmd_pkg;

    // command opcodes carried on cmd_op
    typedef enum logic {
        OP_APPEND = 1'b0,
        OP_CLEAR  = 1'b1
    } log_op_t;

    // ST_PENDING holds one entry until the arbiter grants it
    typedef enum logic {
        ST_IDLE    = 1'b0,
        ST_PENDING = 1'b1
    } writer_state_t;

endpackage : log_cmd_pkg

/* rtl/log_mem_pkg.sv */
package log_mem_pkg;

    // width of one log entry
    localparam int DATA_WIDTH = 16;

    // peer writers sharing the RAM write port
    localparam int NUM_CHANNELS = 2;

    // each channel owns one contiguous region
    localparam int REGION_WORDS = 16;

    // slot index inside a region
    localparam int PTR_WIDTH = $clog2(REGION_WORDS);

    // whole RAM, all regions back to back
    localparam int MEM_WORDS = NUM_CHANNELS * REGION_WORDS;

    // full RAM address, region select on top of the slot index
    localparam int ADDR_WIDTH = $clog2(MEM_WORDS);

    // registers between the array and rd_data
    localparam int READ_LATENCY = 2;

endpackage : log_mem_pkg
